// File: hw/bestHopTracker.sv
`include "qtu_defs.svh"

module bestHopTracker
    import qtuPkg::*;
(
    input  logic clk,
    input  logic nrst,
    pktIf.sink   pkt,
    stepIf.dp    step,
    input  wordT myClusterHead,
    input  wordT myHopsFromCH,
    output wordT nextHop,
    output wordT nextHopCount
);

    wordT hopsNeeded;
    wordT maxQ;
    wordT bestId;
    logic candidate;
    logic betterQ;
    logic tieLowerId;

    // a candidate sits one hop closer to the cluster head than we do
    // a node at hop 0 wraps to the all-ones no-hops value
    assign hopsNeeded = myHopsFromCH - 1'b1;

    assign candidate  = step.isDestination && (pkt.hopsFromCH == hopsNeeded);
    assign betterQ    = (pkt.qValue > maxQ);
    // lower id wins on equal q
    assign tieLowerId = (pkt.qValue == maxQ) && (pkt.sourceID < bestId);

    // running best over all packets since the last clear
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            maxQ   <= '0;
            bestId <= `QTU_NO_HOPS;
        end else if (step.doClear) begin
            maxQ   <= '0;
            bestId <= `QTU_NO_HOPS;
        end else if (step.doProcess && candidate && (betterQ || tieLowerId)) begin
            maxQ   <= pkt.qValue;
            bestId <= pkt.sourceID;
        end
    end

    // next-hop registers follow the output step
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            nextHop      <= '0;
            nextHopCount <= `QTU_NO_HOPS;
        end else if (step.doClear) begin
            nextHop      <= '0;
            nextHopCount <= `QTU_NO_HOPS;
        end else if (step.doOutput) begin
            nextHopCount <= hopsNeeded;
            // cluster head itself is the next hop when one hop away
            if (myHopsFromCH == wordT'(1)) begin
                nextHop <= myClusterHead;
            end else begin
                nextHop <= bestId;
            end
        end
    end

endmodule

// File: hw/neighborTable.sv
`include "qtu_defs.svh"

module neighborTable
    import qtuPkg::*;
(
    input  logic  clk,
    input  logic  nrst,
    pktIf.sink    pkt,
    stepIf.dp     step,
    input  wordT  myClusterHead,
    output wordT  nodeID,
    output wordT  nodeHops,
    output wordT  nodeEnergy,
    output wordT  nodeQValue,
    output countT neighborCount
);

    neighborEntryT tbl [`QTU_TABLE_DEPTH];

    logic     chMatch;
    logic     idHit;
    logic     haveFree;
    logic     accept;
    tableIdxT hitIdx;
    tableIdxT freeIdx;
    tableIdxT wrIdx;

    // slot written by the last process step
    tableIdxT lastIdx;
    logic     lastAccepted;

    // only neighbors of our own cluster are kept
    assign chMatch = (pkt.chosenCH == myClusterHead);

    // scan high to low so the lowest free slot is left in freeIdx
    always_comb begin
        idHit    = 1'b0;
        hitIdx   = '0;
        haveFree = 1'b0;
        freeIdx  = '0;
        for (int i = `QTU_TABLE_DEPTH - 1; i >= 0; i--) begin
            // ids are unique in the table, at most one hit
            if (tbl[i].valid && (tbl[i].id == pkt.sourceID)) begin
                idHit  = 1'b1;
                hitIdx = tableIdxT'(i);
            end
            if (!tbl[i].valid) begin
                haveFree = 1'b1;
                freeIdx  = tableIdxT'(i);
            end
        end
    end

    // known id overwrites in place, new id needs a free slot
    assign accept = chMatch && (idHit || haveFree);
    assign wrIdx  = idHit ? hitIdx : freeIdx;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < `QTU_TABLE_DEPTH; i++) begin
                tbl[i] <= '0;
            end
        end else if (step.doClear) begin
            // heartbeat drops every neighbor
            for (int i = 0; i < `QTU_TABLE_DEPTH; i++) begin
                tbl[i].valid <= 1'b0;
            end
        end else if (step.doProcess && accept) begin
            tbl[wrIdx] <= '{
                valid:      1'b1,
                id:         pkt.sourceID,
                sourceHops: pkt.sourceHops,
                energy:     pkt.energyLeft,
                qValue:     pkt.qValue,
                hopsFromCH: pkt.hopsFromCH
            };
        end
    end

    // count moves only when a new slot is taken
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            neighborCount <= '0;
        end else if (step.doClear) begin
            neighborCount <= '0;
        end else if (step.doProcess && accept && !idHit) begin
            neighborCount <= neighborCount + 1'b1;
        end
    end

    // remember the outcome for the output step
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            lastAccepted <= 1'b0;
            lastIdx      <= '0;
        end else if (step.doProcess) begin
            lastAccepted <= accept;
            lastIdx      <= wrIdx;
        end
    end

    // report the slot just written, dropped packets leave it alone
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            nodeID     <= '0;
            nodeHops   <= `QTU_NO_HOPS;
            nodeEnergy <= '0;
            nodeQValue <= '0;
        end else if (step.doOutput && lastAccepted) begin
            nodeID     <= tbl[lastIdx].id;
            nodeHops   <= tbl[lastIdx].sourceHops;
            nodeEnergy <= tbl[lastIdx].energy;
            nodeQValue <= tbl[lastIdx].qValue;
        end
    end

endmodule

// File: hw/qtuControl.sv
`include "qtu_defs.svh"

module qtuControl
    import qtuPkg::*;
(
    input  logic clk,
    input  logic nrst,
    input  logic en,
    input  logic iAmDestination,
    input  logic hbReset,
    stepIf.ctrl  step,
    output logic done
);

    qtuStateT state;
    logic     idle;
    logic     startPkt;

    assign idle = (state == stIdle);
    // heartbeat reset wins, the packet is lost
    assign startPkt = idle && en && !hbReset;

    // idle -> process -> output -> idle
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= stIdle;
        end else begin
            case (state)
                stIdle: begin
                    if (startPkt) begin
                        state <= stProcess;
                    end
                end
                stProcess: state <= stOutput;
                stOutput:  state <= stIdle;
                default:   state <= stIdle;
            endcase
        end
    end

    // steps are state decodes, so they come straight from flops
    assign step.doProcess = (state == stProcess);
    assign step.doOutput  = (state == stOutput);

    // clear only from idle, one cycle per sampled level
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            step.doClear <= 1'b0;
        end else begin
            step.doClear <= idle && hbReset;
        end
    end

    // destination flag latched with the accepted packet
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            step.isDestination <= 1'b0;
        end else if (startPkt) begin
            step.isDestination <= iAmDestination;
        end
    end

    // done lines up with the output registers
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            done <= 1'b0;
        end else begin
            done <= (state == stOutput);
        end
    end

endmodule

// File: hw/qtuFmbTop.sv
`include "qtu_defs.svh"

module qtuFmbTop
    import qtuPkg::*;
(
    input  logic  clk,
    input  logic  nrst,
    input  logic  en,
    input  logic  iAmDestination,
    input  logic  HB_Reset,
    // received packet
    input  wordT  fSourceID,
    input  wordT  fSourceHops,
    input  wordT  fQValue,
    input  wordT  fEnergyLeft,
    input  wordT  fHopsFromCH,
    input  wordT  fChosenCH,
    // own cluster membership
    input  wordT  chosenCH,
    input  wordT  hopsFromCH,
    // last accepted neighbor
    output wordT  nodeID,
    output wordT  nodeHops,
    output wordT  nodeEnergy,
    output wordT  nodeQValue,
    output wordT  nextHop,
    output wordT  nextHopCount,
    output countT neighborCount,
    output logic  QTUFMB_done
);

    pktIf  pkt ();
    stepIf step ();

    // packet ports feed the interface continuously
    assign pkt.sourceID   = fSourceID;
    assign pkt.sourceHops = fSourceHops;
    assign pkt.qValue     = fQValue;
    assign pkt.energyLeft = fEnergyLeft;
    assign pkt.hopsFromCH = fHopsFromCH;
    assign pkt.chosenCH   = fChosenCH;

    qtuControl u_qtuControl (
        .clk            (clk),
        .nrst           (nrst),
        .en             (en),
        .iAmDestination (iAmDestination),
        .hbReset        (HB_Reset),
        .step           (step.ctrl),
        .done           (QTUFMB_done)
    );

    neighborTable u_neighborTable (
        .clk           (clk),
        .nrst          (nrst),
        .pkt           (pkt.sink),
        .step          (step.dp),
        .myClusterHead (chosenCH),
        .nodeID        (nodeID),
        .nodeHops      (nodeHops),
        .nodeEnergy    (nodeEnergy),
        .nodeQValue    (nodeQValue),
        .neighborCount (neighborCount)
    );

    bestHopTracker u_bestHopTracker (
        .clk           (clk),
        .nrst          (nrst),
        .pkt           (pkt.sink),
        .step          (step.dp),
        .myClusterHead (chosenCH),
        .myHopsFromCH  (hopsFromCH),
        .nextHop       (nextHop),
        .nextHopCount  (nextHopCount)
    );

endmodule

// File: hw/qtuIf.sv
`include "qtu_defs.svh"

// packet fields, held stable by the source from en until done
interface pktIf
    import qtuPkg::*;
();
    wordT sourceID;
    wordT sourceHops;
    wordT qValue;
    wordT energyLeft;
    wordT hopsFromCH;
    // cluster head the sender belongs to
    wordT chosenCH;

    modport src (
        output sourceID, sourceHops, qValue, energyLeft, hopsFromCH, chosenCH
    );

    modport sink (
        input sourceID, sourceHops, qValue, energyLeft, hopsFromCH, chosenCH
    );
endinterface

// one-cycle steps from the controller to the datapath
interface stepIf;
    logic doProcess;
    logic doOutput;
    logic doClear;
    // iAmDestination as seen with en
    logic isDestination;

    modport ctrl (
        output doProcess, doOutput, doClear, isDestination
    );

    modport dp (
        input doProcess, doOutput, doClear, isDestination
    );
endinterface

// File: hw/qtuPkg.sv
`include "qtu_defs.svh"

package qtuPkg;

    // one packet field
    typedef logic [`QTU_WORD_WIDTH-1:0] wordT;

    // slot number inside the neighbor table
    typedef logic [$clog2(`QTU_TABLE_DEPTH)-1:0] tableIdxT;

    // number of valid slots, 0 up to a full table
    typedef logic [`QTU_COUNT_WIDTH-1:0] countT;

    // one neighbor table slot
    typedef struct packed {
        logic valid;
        // neighbor node id
        wordT id;
        // hops the neighbor reported for itself
        wordT sourceHops;
        wordT energy;
        wordT qValue;
        // neighbor distance to the cluster head
        wordT hopsFromCH;
    } neighborEntryT;

    // controller sequence
    typedef enum logic [1:0] {
        stIdle    = 2'd0,
        stProcess = 2'd1,
        stOutput  = 2'd2
    } qtuStateT;

endpackage

// File: hw/qtu_defs.svh
`ifndef QTU_DEFS_SVH
`define QTU_DEFS_SVH

// every packet field is one word
`define QTU_WORD_WIDTH 16

// neighbor slots per node
`define QTU_TABLE_DEPTH 32

// one bit more than the index so a full table fits
`define QTU_COUNT_WIDTH 6

// unknown hop count, also the empty best-neighbor id
`define QTU_NO_HOPS {`QTU_WORD_WIDTH{1'b1}}

`endif

// File: sources.f
+incdir+hw
hw/qtuPkg.sv
hw/qtuIf.sv
hw/qtuControl.sv
hw/neighborTable.sv
hw/bestHopTracker.sv
hw/qtuFmbTop.sv
verification/qtuFmbTb.sv

// File: verification/qtuFmbTb.sv
`include "qtu_defs.svh"

module qtuFmbTb
    import qtuPkg::*;
();

    // run length and the cycle budget derived from it
    localparam int numPkts      = 400;
    localparam int cyclesPerPkt = 5;
    localparam int maxCycles    = 2 * numPkts * cyclesPerPkt;
    // id pool larger than the table so it fills
    localparam int   idPool = 48;
    localparam wordT idBase = 16'h0100;
    // the two cluster heads in play
    localparam wordT chA = 16'h00a0;
    localparam wordT chB = 16'h00b7;

    logic  clk;
    logic  nrst;
    logic  en;
    logic  iAmDestination;
    logic  hbReset;
    wordT  fSourceID;
    wordT  fSourceHops;
    wordT  fQValue;
    wordT  fEnergyLeft;
    wordT  fHopsFromCH;
    wordT  fChosenCH;
    wordT  chosenCH;
    wordT  hopsFromCH;
    wordT  nodeID;
    wordT  nodeHops;
    wordT  nodeEnergy;
    wordT  nodeQValue;
    wordT  nextHop;
    wordT  nextHopCount;
    countT neighborCount;
    logic  done;

    // reference model state
    logic mValid [`QTU_TABLE_DEPTH];
    wordT mId [`QTU_TABLE_DEPTH];
    int   mCount;
    wordT mNodeId;
    wordT mNodeHops;
    wordT mNodeEnergy;
    wordT mNodeQ;
    wordT mBestId;
    wordT mMaxQ;
    wordT mNextHop;
    wordT mNextHopCount;

    integer seed;
    string  testName;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    // packets lost to a full table
    int     drops = 0;

    qtuFmbTop u_qtuFmbTop (
        .clk            (clk),
        .nrst           (nrst),
        .en             (en),
        .iAmDestination (iAmDestination),
        .HB_Reset       (hbReset),
        .fSourceID      (fSourceID),
        .fSourceHops    (fSourceHops),
        .fQValue        (fQValue),
        .fEnergyLeft    (fEnergyLeft),
        .fHopsFromCH    (fHopsFromCH),
        .fChosenCH      (fChosenCH),
        .chosenCH       (chosenCH),
        .hopsFromCH     (hopsFromCH),
        .nodeID         (nodeID),
        .nodeHops       (nodeHops),
        .nodeEnergy     (nodeEnergy),
        .nodeQValue     (nodeQValue),
        .nextHop        (nextHop),
        .nextHopCount   (nextHopCount),
        .neighborCount  (neighborCount),
        .QTUFMB_done    (done)
    );

    always #4 clk = ~clk;

    // hard stop if done never comes
    always @(posedge clk) begin
        cycles++;
        if (cycles >= maxCycles) begin
            $display("timeout, run still going after %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic int unsigned randBelow(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic compareValue(input string what, input logic [15:0] expected,
                                input logic [15:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s %s expected %h actual %h", testName, what, expected, actual);
        end
    endtask

    task automatic checkOutputs();
        compareValue("nodeID", mNodeId, nodeID);
        compareValue("nodeHops", mNodeHops, nodeHops);
        compareValue("nodeEnergy", mNodeEnergy, nodeEnergy);
        compareValue("nodeQValue", mNodeQ, nodeQValue);
        compareValue("nextHop", mNextHop, nextHop);
        compareValue("nextHopCount", mNextHopCount, nextHopCount);
        compareValue("neighborCount", 16'(mCount), 16'(neighborCount));
    endtask

    // heartbeat clears table, count and search, report keeps its value
    task automatic modelClear();
        for (int i = 0; i < `QTU_TABLE_DEPTH; i++) begin
            mValid[i] = 1'b0;
            mId[i]    = '0;
        end
        mCount        = 0;
        mMaxQ         = '0;
        mBestId       = `QTU_NO_HOPS;
        mNextHop      = '0;
        mNextHopCount = `QTU_NO_HOPS;
    endtask

    // one packet through the model, from the current stimulus
    task automatic modelPacket();
        int   hit;
        int   free;
        wordT hopsNeeded;
        hit  = -1;
        free = -1;
        if (fChosenCH == chosenCH) begin
            for (int i = 0; i < `QTU_TABLE_DEPTH; i++) begin
                if (mValid[i] && (mId[i] == fSourceID)) begin
                    hit = i;
                end
                if (!mValid[i] && (free < 0)) begin
                    free = i;
                end
            end
            // new id takes a free slot, full table drops it
            if ((hit < 0) && (free >= 0)) begin
                mValid[free] = 1'b1;
                mId[free]    = fSourceID;
                mCount++;
                hit = free;
            end else if (hit < 0) begin
                drops++;
            end
            if (hit >= 0) begin
                mNodeId     = fSourceID;
                mNodeHops   = fSourceHops;
                mNodeEnergy = fEnergyLeft;
                mNodeQ      = fQValue;
            end
        end
        hopsNeeded = (hopsFromCH == '0) ? `QTU_NO_HOPS : hopsFromCH - 16'd1;
        // best among neighbors one hop closer, lower id on equal q
        if (iAmDestination && (fHopsFromCH == hopsNeeded)) begin
            if ((fQValue > mMaxQ) || ((fQValue == mMaxQ) && (fSourceID < mBestId))) begin
                mMaxQ   = fQValue;
                mBestId = fSourceID;
            end
        end
        mNextHopCount = hopsNeeded;
        mNextHop      = (hopsFromCH == 16'd1) ? chosenCH : mBestId;
    endtask

    // called one unit after a rising edge
    task automatic sendPacket(input int n);
        testName       = $sformatf("packet %0d", n);
        fSourceID      = idBase + wordT'(randBelow(idPool));
        fSourceHops    = wordT'(randBelow(8));
        // small q range so ties happen
        fQValue        = wordT'(randBelow(16));
        fEnergyLeft    = wordT'(randBelow(65536));
        fHopsFromCH    = wordT'(1 + randBelow(4));
        // three in four packets belong to our cluster
        fChosenCH      = (randBelow(4) != 0) ? chosenCH : ((chosenCH == chA) ? chB : chA);
        hopsFromCH     = wordT'(1 + randBelow(4));
        iAmDestination = (randBelow(4) != 0);
        en             = 1'b1;
        @(posedge clk);
        #1;
        en = 1'b0;
        modelPacket();
        while (done !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        checkOutputs();
        // done is a single-cycle pulse
        @(posedge clk);
        #1;
        compareValue("done after pulse", 1'b0, done);
    endtask

    // heartbeat pulse in idle, optionally racing an en
    task automatic heartbeat(input bit withEn);
        testName = withEn ? "heartbeat with en" : "heartbeat";
        hbReset  = 1'b1;
        en       = withEn;
        @(posedge clk);
        #1;
        hbReset = 1'b0;
        en      = 1'b0;
        modelClear();
        // lost en must not start a packet
        repeat (3) begin
            @(posedge clk);
            #1;
            compareValue("done", 1'b0, done);
        end
        checkOutputs();
        // switch cluster so the fresh table sees a new head
        chosenCH = (chosenCH == chA) ? chB : chA;
    endtask

    initial begin
        clk            = 1'b0;
        nrst           = 1'b0;
        en             = 1'b0;
        iAmDestination = 1'b0;
        hbReset        = 1'b0;
        fSourceID      = '0;
        fSourceHops    = '0;
        fQValue        = '0;
        fEnergyLeft    = '0;
        fHopsFromCH    = '0;
        fChosenCH      = '0;
        chosenCH       = chA;
        hopsFromCH     = 16'd2;
        seed           = 32'h8ca4_2bf6;
        modelClear();
        mNodeId     = '0;
        mNodeHops   = `QTU_NO_HOPS;
        mNodeEnergy = '0;
        mNodeQ      = '0;
        repeat (3) @(posedge clk);
        #1;
        nrst     = 1'b1;
        testName = "after reset";
        checkOutputs();
        compareValue("done", 1'b0, done);
        for (int n = 0; n < numPkts; n++) begin
            if ((n > 0) && (n % 100 == 0)) begin
                heartbeat(n % 200 == 0);
            end
            sendPacket(n);
        end
        if (drops == 0) begin
            errors++;
            $display("the neighbor table never filled up, full-table drop not exercised");
        end
        $display("%0d checks, %0d errors, %0d full-table drops", checks, errors, drops);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
